//--- project.f
src/piano_pkg.sv
src/noise_pkg.sv
src/input_conditioner.sv
src/control_panel.sv
src/tone_divider.sv
src/noise_lfsr.sv
src/voice_bank.sv
src/piano_top.sv
+incdir+sim
sim/piano_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the organ testbench with verilator, result decided from the log
verilator --binary --timing --assert -Wno-fatal --top-module piano_tb -f project.f \
  -o piano_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/piano_sim > sim.log 2>&1 || { echo "simulation error, see sim.log"; exit 1; }
grep -q "Test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || { echo "PASS"; exit 0; }

//--- sim/piano_checks.svh
`ifndef PIANO_CHECKS_SVH
`define PIANO_CHECKS_SVH

// one clock, then step off the edge so outputs are settled and inputs can change
task automatic tick();
  @(posedge clk);
  #stim_delay;
endtask

function automatic logic note_bit(input piano_pkg::note_set_t n, input int idx);
  logic [piano_pkg::num_voices-1:0] bits;
  bits = n;
  return bits[idx];
endfunction

// expected note word with a single voice at a given level
function automatic piano_pkg::note_set_t one_note(input int idx, input logic val);
  logic [piano_pkg::num_voices-1:0] bits;
  bits = '0;
  bits[idx] = val;
  return piano_pkg::note_set_t'(bits);
endfunction

task automatic check_notes(input string name, input piano_pkg::note_set_t expected,
                           input piano_pkg::note_set_t actual);
  if (actual !== expected) begin
    $display("[FAIL] %s: expected notes %b, actual %b", name, expected, actual);
    error_count++;
  end
endtask

task automatic check_mode_interval(input string name, input int expected, input int actual);
  if (actual != expected) begin
    $display("[FAIL] %s: expected %0d cycles, actual %0d", name, expected, actual);
    error_count++;
  end
endtask

// galois step: top bit leaves, comes back at bit 0 and flips the tapped bits
function automatic noise_pkg::lfsr_state_t lfsr_next(input noise_pkg::lfsr_state_t state,
                                                    input noise_pkg::lfsr_state_t taps);
  noise_pkg::lfsr_state_t next;
  logic out_bit;
  out_bit = state[noise_pkg::lfsr_width-1];
  next = state << 1;
  next[0] = out_bit;
  if (out_bit) next = next ^ (taps & 8'hfe);
  return next;
endfunction

// counts cycles until one note output moves, cycles is -1 on timeout
task automatic wait_change(input string name, input int idx, input int limit,
                           output int cycles);
  logic start;
  int n;
  start = note_bit(notes, idx);
  cycles = -1;
  n = 0;
  while (n < limit && cycles < 0) begin
    tick();
    n++;
    if (note_bit(notes, idx) !== start) cycles = n;
  end
  if (cycles < 0) begin
    $display("%s: note %0d did not change within %0d cycles", name, idx, limit);
    error_count++;
  end
endtask

task automatic wait_silent(input string name, input int limit);
  int n;
  n = 0;
  while (n < limit && notes !== '0) begin
    tick();
    n++;
  end
  if (notes !== '0) begin
    $display("%s: notes still sounding %0d cycles after release", name, limit);
    error_count++;
  end
endtask

`endif

//--- sim/piano_tb.sv
`timescale 1ns/1ps

module piano_tb;

  localparam int stim_delay = 2;
  localparam int reset_cycles = 4;
  localparam int debounce_allow = 6;  // raw switch change until the key is seen high
  localparam int voice_c = 0;
  localparam int voice_a = 5;
  localparam int voice_c2 = 7;

  logic clk;
  logic rst;
  logic btn;
  piano_pkg::note_set_t sw;
  piano_pkg::note_set_t notes;

  int error_count;
  int test_count;
  int failed_tests;
  int errors_at_start;
  integer seed;
  noise_pkg::lfsr_state_t lfsr_model [piano_pkg::num_voices];  // lfsrs keep state across tests

  `include "piano_checks.svh"

  piano_top i_piano_top (
    .clk   (clk),
    .rst   (rst),
    .btn   (btn),
    .sw    (sw),
    .notes (notes)
  );

  always #20 clk = ~clk;

  task automatic set_key(input int idx, input logic val);
    logic [piano_pkg::num_voices-1:0] bits;
    bits = sw;
    bits[idx] = val;
    sw = piano_pkg::note_set_t'(bits);
  endtask

  task automatic press_button();
    btn = 1'b1;
    repeat (10) tick();  // well past the debounce window
    btn = 1'b0;
    repeat (10) tick();
  endtask

  task automatic start_test();
    errors_at_start = error_count;
    test_count++;
  endtask

  task automatic finish_test(input string name);
    sw = '0;
    btn = 1'b0;
    wait_silent(name, 20);
    if (error_count == errors_at_start) begin
      $display("[PASS] %s", name);
    end else begin
      $display("[FAIL] %s: %0d errors", name, error_count - errors_at_start);
      failed_tests++;
    end
  endtask

  // toggles until the model lfsr low bit is 1, where noise would bend the waveform
  function automatic int edges_to_expose(input int idx);
    noise_pkg::lfsr_state_t probe;
    int steps;
    probe = lfsr_next(lfsr_model[idx], noise_pkg::lfsr_taps[idx]);
    steps = 1;
    while (!probe[0] && steps < 255) begin
      probe = lfsr_next(probe, noise_pkg::lfsr_taps[idx]);
      steps++;
    end
    return (steps < 2) ? 2 : steps;
  endfunction

  // in pure mode every output change is one tone toggle
  task automatic pitch_check(input string name, input int idx, input int edges);
    int cycles;
    int limit;
    logic tone;
    limit = piano_pkg::half_period[idx] + 20;
    tone = 1'b0;
    set_key(idx, 1'b1);
    for (int k = 0; k <= edges; k++) begin
      wait_change(name, idx, limit, cycles);
      if (cycles < 0) return;
      if (k > 0) check_mode_interval(name, piano_pkg::half_period[idx] + 1, cycles);
      tone = ~tone;
      lfsr_model[idx] = lfsr_next(lfsr_model[idx], noise_pkg::lfsr_taps[idx]);
      check_notes(name, one_note(idx, tone), notes);
    end
    set_key(idx, 1'b0);
    wait_silent(name, 20);
  endtask

  // watches two voices at once and stops after vb shows enough edges
  task automatic track_pair(input string name, input int va, input int vb,
                            input int edges_b, input logic va_off);
    int v [2];
    int last [2];
    logic prev [2];
    int count_b;
    int n;
    int limit;
    v[0] = va;
    v[1] = vb;
    limit = (edges_b + 1) * (piano_pkg::half_period[vb] + 1) + 50;
    count_b = 0;
    n = 0;
    for (int j = 0; j < 2; j++) begin
      last[j] = -1;
      prev[j] = note_bit(notes, v[j]);
    end
    while (n < limit && count_b < edges_b) begin
      tick();
      n++;
      for (int j = 0; j < 2; j++) begin
        if (note_bit(notes, v[j]) !== prev[j]) begin
          if (last[j] >= 0) begin
            check_mode_interval(name, piano_pkg::half_period[v[j]] + 1, n - last[j]);
          end
          last[j] = n;
          prev[j] = note_bit(notes, v[j]);
          lfsr_model[v[j]] = lfsr_next(lfsr_model[v[j]], noise_pkg::lfsr_taps[v[j]]);
          if (j == 1) count_b++;
        end
      end
      if (va_off && note_bit(notes, va) !== 1'b0) begin
        $display("%s: released note %0d is sounding again", name, va);
        error_count++;
        return;
      end
    end
    if (count_b < edges_b) begin
      $display("%s: note %0d stopped toggling after %0d cycles", name, vb, limit);
      error_count++;
    end
  endtask

  task automatic test_reset_state();
    start_test();
    repeat (20) begin
      tick();
      check_notes("reset_state", '0, notes);
    end
    finish_test("reset_state");
  endtask

  task automatic test_pitch();
    start_test();
    pitch_check("pitch_c2", voice_c2, 3);
    pitch_check("pitch_a", voice_a, 3);
    finish_test("pitch");
  endtask

  task automatic test_glitch();
    start_test();
    set_key(voice_c, 1'b1);
    repeat (2) tick();
    set_key(voice_c, 1'b0);
    btn = 1'b1;
    repeat (2) tick();
    btn = 1'b0;
    // long enough to see a first toggle had the pulse got through
    for (int n = 0; n < piano_pkg::half_period[voice_c] + 20; n++) begin
      tick();
      if (notes !== '0) begin
        check_notes("glitch_quiet", '0, notes);
        break;
      end
    end
    pitch_check("glitch_still_pure", voice_c2, edges_to_expose(voice_c2));
    finish_test("glitch");
  endtask

  task automatic test_noise_mode();
    int hp;
    logic tone;
    start_test();
    hp = piano_pkg::half_period[voice_c2];
    tone = 1'b0;
    press_button();
    set_key(voice_c2, 1'b1);
    // key seen high after the debounce and first toggle hp+1 later, plus the register
    repeat (hp + 8) tick();
    for (int k = 0; k < 8; k++) begin
      if (k > 0) repeat (hp + 1) tick();
      tone = ~tone;
      lfsr_model[voice_c2] = lfsr_next(lfsr_model[voice_c2], noise_pkg::lfsr_taps[voice_c2]);
      check_notes("noise_edge", one_note(voice_c2, tone ^ lfsr_model[voice_c2][0]), notes);
    end
    set_key(voice_c2, 1'b0);
    wait_silent("noise_mode", 20);
    press_button();
    pitch_check("noise_back_to_pure", voice_c2, edges_to_expose(voice_c2));
    finish_test("noise_mode");
  endtask

  task automatic test_release_restart();
    int va;
    int vb;
    int n;
    int cycles;
    start_test();
    va = $unsigned($random(seed)) % piano_pkg::num_voices;
    vb = (va + 1 + $unsigned($random(seed)) % (piano_pkg::num_voices - 1))
         % piano_pkg::num_voices;
    $display("release_restart: voices %0d and %0d", va, vb);
    set_key(va, 1'b1);
    set_key(vb, 1'b1);
    track_pair("both_playing", va, vb, 3, 1'b0);
    set_key(va, 1'b0);
    repeat (debounce_allow) tick();  // key low by now
    n = 0;
    while (n < 8 && note_bit(notes, va) !== 1'b0) begin
      tick();
      n++;
    end
    if (note_bit(notes, va) !== 1'b0) begin
      $display("release_restart: note %0d did not go quiet after release", va);
      error_count++;
    end
    track_pair("one_released", va, vb, 2, 1'b1);
    set_key(va, 1'b1);
    wait_change("restart", va, piano_pkg::half_period[va] + debounce_allow + 20, cycles);
    if (cycles >= 0) begin
      // the output register adds one cycle on top of the debounce
      check_mode_interval("restart_first_edge", piano_pkg::half_period[va] + 1,
                          cycles - debounce_allow - 1);
    end
    finish_test("release_restart");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    btn = 1'b0;
    sw = '0;
    seed = 84546;
    error_count = 0;
    test_count = 0;
    failed_tests = 0;
    errors_at_start = 0;
    for (int i = 0; i < piano_pkg::num_voices; i++) lfsr_model[i] = noise_pkg::lfsr_seed[i];
    repeat (reset_cycles) tick();
    rst = 1'b0;

    test_reset_state();
    test_pitch();
    test_glitch();
    test_noise_mode();
    test_release_restart();

    $display("summary: %0d tests, %0d failed, %0d errors",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- src/control_panel.sv
`timescale 1ns/1ps

module control_panel (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   btn,
  input  piano_pkg::note_set_t   sw,
  output piano_pkg::note_set_t   keys,
  output piano_pkg::voice_mode_t mode
);

  logic [piano_pkg::num_voices-1:0] sw_bits;
  logic [piano_pkg::num_voices-1:0] key_bits;
  logic btn_rise;

  assign sw_bits = sw;
  assign keys    = piano_pkg::note_set_t'(key_bits);

  // only the press strobe of the button matters
  input_conditioner i_btn_cond (
    .clk         (clk),
    .rst         (rst),
    .noisy       (btn),
    .conditioned (),
    .rise        (btn_rise)
  );

  generate
    for (genvar i = 0; i < piano_pkg::num_voices; i++) begin : g_sw
      input_conditioner i_sw_cond (
        .clk         (clk),
        .rst         (rst),
        .noisy       (sw_bits[i]),
        .conditioned (key_bits[i]),  // keys are plain levels
        .rise        ()
      );
    end
  endgenerate

  // each press swaps between pure tone and noise
  always_ff @(posedge clk) begin
    if (rst) begin
      mode <= piano_pkg::mode_pure;
    end else if (btn_rise) begin
      mode <= (mode == piano_pkg::mode_pure) ? piano_pkg::mode_noise
                                             : piano_pkg::mode_pure;
    end
  end

endmodule

//--- src/input_conditioner.sv
`timescale 1ns/1ps

module input_conditioner (
  input  logic clk,
  input  logic rst,
  input  logic noisy,
  output logic conditioned,
  output logic rise
);

  logic sync0;
  logic sync1;
  logic [piano_pkg::debounce_width-1:0] counter;
  logic settled;

  // disagreement has lasted long enough
  assign settled = (int'(counter) == piano_pkg::debounce_wait);

  always_ff @(posedge clk) begin
    if (rst) begin
      sync0       <= 1'b0;
      sync1       <= 1'b0;
      counter     <= '0;
      conditioned <= 1'b0;
      rise        <= 1'b0;
    end else begin
      sync0 <= noisy;
      sync1 <= sync0;
      rise  <= 1'b0;
      if (sync1 == conditioned) begin
        counter <= '0;  // agreement restarts the wait
      end else if (settled) begin
        counter     <= '0;
        conditioned <= sync1;
        rise        <= sync1;  // new level 1 means a 0->1 change
      end else begin
        counter <= counter + 1'b1;
      end
    end
  end

  rise_single: assert property (@(posedge clk) disable iff (rst)
    rise |=> !rise);

  // the level may only move at the end of a full debounce window
  level_waits: assert property (@(posedge clk) disable iff (rst)
    $changed(conditioned) |-> $past(settled));

endmodule

//--- src/noise_lfsr.sv
`timescale 1ns/1ps

module noise_lfsr #(
  parameter noise_pkg::lfsr_state_t taps = 8'h1c,
  parameter noise_pkg::lfsr_state_t seed = 8'hff
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   step,
  output noise_pkg::lfsr_state_t state
);

  localparam int w = noise_pkg::lfsr_width;

  logic feedback;

  assign feedback = state[w-1];  // bit shifted out at the top

  // galois step: shift left, feedback into bit 0 and the tap positions
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= seed;
    end else if (step) begin
      state <= {state[w-2:0] ^ (taps[w-1:1] & {(w-1){feedback}}), feedback};
    end
  end

  // a zero state would lock up and silence the noise
  never_zero: assert property (@(posedge clk) disable iff (rst)
    state != '0);

endmodule

//--- src/noise_pkg.sv
package noise_pkg;

  localparam int lfsr_width = 8;

  typedef logic [lfsr_width-1:0] lfsr_state_t;

  // galois tap masks, a set bit i means the feedback is xored into bit i
  // bit 0 always takes the feedback directly, so it stays clear here
  localparam lfsr_state_t lfsr_taps [piano_pkg::num_voices] = '{
    8'h1c,  // c   taps 2 3 4
    8'h54,  // d   taps 2 4 6
    8'h84,  // e   taps 2 7
    8'h0a,  // f   taps 1 3
    8'h14,  // g   taps 2 4
    8'h44,  // a   taps 2 6
    8'h1c,  // b   taps 2 3 4
    8'h86   // c2  taps 1 2 7
  };

  // start values, all nonzero
  localparam lfsr_state_t lfsr_seed [piano_pkg::num_voices] = '{
    8'hff,
    8'hdf,
    8'h55,
    8'hef,
    8'hf8,
    8'h66,
    8'hff,
    8'haa
  };

endpackage

//--- src/piano_pkg.sv
package piano_pkg;

  localparam int num_voices = 8;
  localparam int div_width = 17;  // wide enough for the lowest note

  // half-period counts at 50 MHz, the tone flips once per wrap
  localparam int unsigned half_period [num_voices] = '{
    95566,  // c   261.6 Hz
    85121,  // d   293.7 Hz
    75850,  // e   329.6 Hz
    71592,  // f   349.2 Hz
    63776,  // g   392.0 Hz
    56818,  // a   440.0 Hz
    50618,  // b   493.9 Hz
    47774   // c2  523.3 Hz
  };

  // cycles of steady disagreement before a conditioned level moves
  localparam int debounce_wait = 3;
  localparam int debounce_width = $clog2(debounce_wait + 1);

  // one bit per key, c sits at bit 0
  typedef struct packed {
    logic c2;
    logic b;
    logic a;
    logic g;
    logic f;
    logic e;
    logic d;
    logic c;
  } note_set_t;

  typedef enum logic {
    mode_pure  = 1'b0,
    mode_noise = 1'b1
  } voice_mode_t;

endpackage

//--- src/piano_top.sv
`timescale 1ns/1ps

module piano_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 btn,    // raw push button
  input  piano_pkg::note_set_t sw,     // raw slide switches
  output piano_pkg::note_set_t notes
);

  piano_pkg::note_set_t   keys;
  piano_pkg::voice_mode_t mode;

  // debounced keys and the pure/noise mode
  control_panel i_control_panel (
    .clk  (clk),
    .rst  (rst),
    .btn  (btn),
    .sw   (sw),
    .keys (keys),
    .mode (mode)
  );

  voice_bank i_voice_bank (
    .clk   (clk),
    .rst   (rst),
    .keys  (keys),
    .mode  (mode),
    .notes (notes)
  );

endmodule

//--- src/tone_divider.sv
`timescale 1ns/1ps

module tone_divider #(
  parameter int unsigned limit = 95566
) (
  input  logic clk,
  input  logic rst,
  input  logic key,
  output logic tone,
  output logic toggle
);

  localparam logic [piano_pkg::div_width-1:0] wrap_at = limit[piano_pkg::div_width-1:0];

  logic [piano_pkg::div_width-1:0] counter;

  // high in the cycle whose clock edge flips the tone
  assign toggle = key && (counter == wrap_at);

  always_ff @(posedge clk) begin
    if (rst || !key) begin
      counter <= '0;  // released key restarts the phase
      tone    <= 1'b0;
    end else if (toggle) begin
      counter <= '0;
      tone    <= ~tone;
    end else begin
      counter <= counter + 1'b1;
    end
  end

  count_in_range: assert property (@(posedge clk) disable iff (rst)
    counter <= wrap_at);

endmodule

//--- src/voice_bank.sv
`timescale 1ns/1ps

module voice_bank (
  input  logic                   clk,
  input  logic                   rst,
  input  piano_pkg::note_set_t   keys,
  input  piano_pkg::voice_mode_t mode,
  output piano_pkg::note_set_t   notes
);

  localparam int nv = piano_pkg::num_voices;

  logic [nv-1:0] key_bits;
  logic [nv-1:0] tone;
  logic [nv-1:0] toggle;
  logic [nv-1:0] mixed;
  noise_pkg::lfsr_state_t lfsr_state [nv];
  logic noise_on;

  assign key_bits = keys;
  assign noise_on = (mode == piano_pkg::mode_noise);

  generate
    for (genvar i = 0; i < nv; i++) begin : g_voice
      tone_divider #(
        .limit (piano_pkg::half_period[i])
      ) i_div (
        .clk    (clk),
        .rst    (rst),
        .key    (key_bits[i]),
        .tone   (tone[i]),
        .toggle (toggle[i])
      );

      // lfsr moves on the same edge as its tone
      noise_lfsr #(
        .taps (noise_pkg::lfsr_taps[i]),
        .seed (noise_pkg::lfsr_seed[i])
      ) i_lfsr (
        .clk   (clk),
        .rst   (rst),
        .step  (toggle[i]),
        .state (lfsr_state[i])
      );

      assign mixed[i] = key_bits[i] & (tone[i] ^ (noise_on & lfsr_state[i][0]));
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (rst) begin
      notes <= '0;
    end else begin
      notes <= piano_pkg::note_set_t'(mixed);  // one cycle behind tone and lfsr
    end
  end

endmodule
